/* bcd_display.f */
bin_bcd_pkg.sv
bin_to_bcd.sv
digit_scan.sv
bcd_display_top.sv
bcd_display_assertions.sv
tb_clock_gen.sv
tb_bcd_display.sv

/* bcd_display_assertions.sv */
`timescale 1ns/10ps

module bcd_display_assertions
    import bin_bcd_pkg::*;
(
    input logic           clk,
    input logic           rst_n,
    input logic           enable,
    input logic           ready,
    input bcd_t           bcd,
    input display_drive_t disp
);

    int unsigned fail_count = 0;   // Failed assertions so far

    // Accept takes the converter busy on the next edge
    property accept_drops_ready;
        @(posedge clk) disable iff (!rst_n)
            (ready && enable) |=> !ready;
    endproperty

    // Busy for exactly BIN_WIDTH cycles, then idle again
    property busy_length;
        @(posedge clk) disable iff (!rst_n)
            $fell(ready) |-> !ready [*BIN_WIDTH] ##1 ready;
    endproperty

    // Held result does not move while idle
    property result_held;
        @(posedge clk) disable iff (!rst_n)
            (ready && $past(ready)) |-> $stable(bcd);
    endproperty

    // Never two digits lit at once
    property one_anode;
        @(posedge clk) disable iff (!rst_n)
            $onehot0(~disp.an);
    endproperty

    a_accept: assert property (accept_drops_ready) else begin
        fail_count++;
        $error("ready still high after accept");
    end

    a_busy: assert property (busy_length) else begin
        fail_count++;
        $error("ready low for a wrong number of cycles");
    end

    a_held: assert property (result_held) else begin
        fail_count++;
        $error("bcd changed while ready");
    end

    a_anode: assert property (one_anode) else begin
        fail_count++;
        $error("more than one anode low");
    end

endmodule

bind bcd_display_top bcd_display_assertions u_assert (
    .clk    (clk),
    .rst_n  (rst_n),
    .enable (enable),
    .ready  (ready),
    .bcd    (bcd),
    .disp   (disp)
);

/* bcd_display_top.sv */
`timescale 1ns/10ps

module bcd_display_top
    import bin_bcd_pkg::*;
(
    input  logic           clk,
    input  logic           rst_n,
    input  logic           enable,   // Conversion start strobe
    input  bin_t           bin,      // Value to convert
    output bcd_t           bcd,      // Converted result
    output logic           ready,    // Converter idle
    output display_drive_t disp      // Seven-segment drive
);

    // Converter result feeds both the port and the scanner
    bcd_t bcd_int;

    assign bcd = bcd_int;

    // Sequential double-dabble converter
    bin_to_bcd u_conv (
        .clk    (clk),
        .rst_n  (rst_n),
        .enable (enable),
        .bin    (bin),
        .bcd    (bcd_int),
        .ready  (ready)
    );

    // Multiplexed display, reads the held result
    digit_scan u_scan (
        .clk   (clk),
        .rst_n (rst_n),
        .bcd   (bcd_int),
        .disp  (disp)
    );

endmodule

/* bin_bcd_pkg.sv */
package bin_bcd_pkg;

    // Converter sizes
    localparam int BIN_WIDTH  = 13;                      // Binary input bits
    localparam int BCD_DIGITS = 4;                       // Decimal digits out
    localparam int BCD_WIDTH  = BCD_DIGITS * 4;          // Packed BCD bits
    localparam int WORK_WIDTH = BCD_WIDTH + BIN_WIDTH;   // Double-dabble shift register
    localparam int BIT_CNT_W  = $clog2(BIN_WIDTH + 1);   // Must hold BIN_WIDTH itself

    // Display scan
    localparam int SCAN_DIV    = 4;                      // Cycles per digit
    localparam int SCAN_CNT_W  = $clog2(SCAN_DIV);
    localparam int DIGIT_IDX_W = $clog2(BCD_DIGITS);

    // Vector types
    typedef logic [BIN_WIDTH-1:0]   bin_t;
    typedef logic [BCD_WIDTH-1:0]   bcd_t;               // Units digit in bits 3:0
    typedef logic [3:0]             digit_t;
    typedef logic [6:0]             seg_t;               // g f e d c b a, active low
    typedef logic [BCD_DIGITS-1:0]  anode_t;             // Active low, bit i = digit i
    typedef logic [WORK_WIDTH-1:0]  work_t;
    typedef logic [BIT_CNT_W-1:0]   bit_cnt_t;
    typedef logic [SCAN_CNT_W-1:0]  scan_cnt_t;
    typedef logic [DIGIT_IDX_W-1:0] digit_idx_t;

    // Display idle patterns
    localparam seg_t   SEG_BLANK = '1;                   // All segments dark
    localparam anode_t ANODE_OFF = '1;                   // No digit selected

    // Converter FSM
    typedef enum logic {
        IDLE,   // Ready, waiting for enable
        SHIFT   // Add-3 and shift, one bit per cycle
    } conv_state_t;

    // Display drive bundle, anodes in the upper bits
    typedef struct packed {
        anode_t an;
        seg_t   seg;
    } display_drive_t;

endpackage

/* bin_to_bcd.sv */
`timescale 1ns/10ps

module bin_to_bcd
    import bin_bcd_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic enable,   // Start strobe, sampled only in IDLE
    input  bin_t bin,
    output bcd_t bcd,      // Held result, updated at end of conversion
    output logic ready     // High while IDLE
);

    conv_state_t state;
    work_t       work;          // BCD nibbles on top, binary bits below
    work_t       work_adj;      // After add-3 correction
    work_t       work_next;     // After correction and shift
    bit_cnt_t    bit_cnt;       // Shifts done so far
    bit_cnt_t    bit_cnt_next;
    logic        accept;        // New value taken this edge
    logic        last_shift;    // This edge finishes the conversion

    assign ready  = (state == IDLE);
    assign accept = ready && enable;

    // Add 3 to every BCD nibble that is 5 or more
    always_comb begin
        work_adj = work;
        for (int i = 0; i < BCD_DIGITS; i++) begin
            if (work[BIN_WIDTH + 4*i +: 4] >= 4'd5) begin
                work_adj[BIN_WIDTH + 4*i +: 4] = work[BIN_WIDTH + 4*i +: 4] + 4'd3;
            end
        end
    end

    // Shift left by one, next binary bit moves into the units nibble
    assign work_next = {work_adj[WORK_WIDTH-2:0], 1'b0};

    assign bit_cnt_next = bit_cnt + 1'b1;
    assign last_shift   = (bit_cnt_next == bit_cnt_t'(BIN_WIDTH));

    // Control state and result register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= IDLE;
            bit_cnt <= '0;
            bcd     <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (accept) begin
                        state   <= SHIFT;
                        bit_cnt <= '0;
                    end
                end
                SHIFT: begin
                    bit_cnt <= bit_cnt_next;
                    if (last_shift) begin
                        state <= IDLE;
                        bcd   <= work_next[WORK_WIDTH-1 -: BCD_WIDTH]; // BCD part only
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Working register, loaded on accept and shifted while busy
    always_ff @(posedge clk) begin
        if (accept) begin
            work <= {{BCD_WIDTH{1'b0}}, bin};   // Clear BCD part, load binary
        end else if (state == SHIFT) begin
            work <= work_next;
        end
    end

endmodule

/* digit_scan.sv */
`timescale 1ns/10ps

module digit_scan
    import bin_bcd_pkg::*;
(
    input  logic           clk,
    input  logic           rst_n,
    input  bcd_t           bcd,    // Read continuously
    output display_drive_t disp    // Registered anode and segment pair
);

    scan_cnt_t  scan_cnt;    // Dwell counter for current digit
    digit_idx_t digit_idx;   // Digit being shown, counts down
    digit_idx_t msd_idx;     // Highest nonzero digit, 0 when value is zero
    digit_t     cur_digit;
    seg_t       seg_dec;
    anode_t     an_dec;
    logic       blank;       // Leading zero above the top digit

    // Dwell counter and digit rotation 3, 2, 1, 0
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            scan_cnt  <= '0;
            digit_idx <= digit_idx_t'(BCD_DIGITS - 1);
        end else if (scan_cnt == scan_cnt_t'(SCAN_DIV - 1)) begin
            scan_cnt <= '0;
            if (digit_idx == '0) begin
                digit_idx <= digit_idx_t'(BCD_DIGITS - 1);   // Wrap to top digit
            end else begin
                digit_idx <= digit_idx - 1'b1;
            end
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    // Highest nonzero digit, later digits overwrite earlier ones
    always_comb begin
        msd_idx = '0;
        for (int i = 0; i < BCD_DIGITS; i++) begin
            if (bcd[4*i +: 4] != 4'd0) begin
                msd_idx = digit_idx_t'(i);
            end
        end
    end

    assign cur_digit = bcd[4*digit_idx +: 4];
    assign blank     = (digit_idx > msd_idx);          // Digit 0 never blanked
    assign an_dec    = ~(anode_t'(1) << digit_idx);    // One anode low

    // Segment decode, g f e d c b a, 0 lights a segment
    always_comb begin
        case (cur_digit)
            4'd0:    seg_dec = 7'h40;
            4'd1:    seg_dec = 7'h79;
            4'd2:    seg_dec = 7'h24;
            4'd3:    seg_dec = 7'h30;
            4'd4:    seg_dec = 7'h19;
            4'd5:    seg_dec = 7'h12;
            4'd6:    seg_dec = 7'h02;
            4'd7:    seg_dec = 7'h78;
            4'd8:    seg_dec = 7'h00;
            4'd9:    seg_dec = 7'h10;
            default: seg_dec = SEG_BLANK;   // Not a BCD code
        endcase
    end

    // Output register, one cycle behind bcd
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            disp.an  <= ANODE_OFF;
            disp.seg <= SEG_BLANK;
        end else begin
            disp.an  <= an_dec;
            disp.seg <= blank ? SEG_BLANK : seg_dec;
        end
    end

endmodule

/* tb_bcd_display.sv */
`timescale 1ns/10ps

module tb_bcd_display
    import bin_bcd_pkg::*;
();

    localparam int CLK_PERIOD      = 20;
    localparam int RESET_CYCLES    = 16;
    localparam int NUM_ROWS        = 10;
    localparam int NUM_RANDOM      = 20;
    localparam int NUM_EXTRA       = 3;                  // Busy run plus two back-to-back
    localparam int CYCLES_PER_RUN  = 16 + 4*SCAN_DIV + 8;
    localparam int WATCHDOG_CYCLES =
        (NUM_ROWS + NUM_RANDOM + NUM_EXTRA) * CYCLES_PER_RUN + RESET_CYCLES;
    localparam logic [31:0] LFSR_SEED = 32'd67274;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;   // x^32 + x^22 + x^2 + x + 1

    typedef struct packed {
        bin_t value;
        bcd_t expected;
    } vector_t;

    logic           clk;
    logic           rst_n;
    logic           enable;
    bin_t           bin;
    bcd_t           bcd;
    logic           ready;
    display_drive_t disp;
    logic [31:0]    lfsr;

    // Expected BCD written out by hand
    vector_t rows [NUM_ROWS] = '{
        '{value: 13'd0,    expected: 16'h0000},
        '{value: 13'd9,    expected: 16'h0009},
        '{value: 13'd10,   expected: 16'h0010},
        '{value: 13'd69,   expected: 16'h0069},
        '{value: 13'd153,  expected: 16'h0153},
        '{value: 13'd255,  expected: 16'h0255},
        '{value: 13'd999,  expected: 16'h0999},
        '{value: 13'd1000, expected: 16'h1000},
        '{value: 13'd4008, expected: 16'h4008},
        '{value: 13'd8191, expected: 16'h8191}
    };

    // Seven-segment patterns in g f e d c b a order with 0 lit
    seg_t seg_table [10] = '{
        7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000, 7'b0011001,
        7'b0010010, 7'b0000010, 7'b1111000, 7'b0000000, 7'b0010000
    };

    tb_clock_gen u_clk (
        .clk   (clk),
        .rst_n (rst_n)
    );

    bcd_display_top u_dut (
        .clk    (clk),
        .rst_n  (rst_n),
        .enable (enable),
        .bin    (bin),
        .bcd    (bcd),
        .ready  (ready),
        .disp   (disp)
    );

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_bcd(input bcd_t expected, input bcd_t actual);
        if (actual !== expected)
            stop_on_error($sformatf("error bcd expected %h got %h", expected, actual));
    endtask

    task automatic check_seg(input seg_t expected, input seg_t actual);
        if (actual !== expected)
            stop_on_error($sformatf("error seg expected %h got %h", expected, actual));
    endtask

    task automatic check_anode(input anode_t expected, input anode_t actual);
        if (actual !== expected)
            stop_on_error($sformatf("error an expected %h got %h", expected, actual));
    endtask

    task automatic check_latency(input integer expected, input integer actual);
        if (actual !== expected)
            stop_on_error($sformatf("error latency expected %0h got %0h", expected, actual));
    endtask

    // Division model with the units digit first
    function automatic bcd_t bcd_model(input int value);
        bcd_t result;
        int   rest;
        result = '0;
        rest   = value;
        for (int i = 0; i < BCD_DIGITS; i++) begin
            result[4*i +: 4] = digit_t'(rest % 10);
            rest = rest / 10;
        end
        return result;
    endfunction

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0])
            return (state >> 1) ^ LFSR_TAPS;
        return state >> 1;
    endfunction

    // One LFSR step per bit taken
    task automatic next_random(output bin_t value);
        value = '0;
        for (int b = 0; b < BIN_WIDTH; b++) begin
            value = {value[BIN_WIDTH-2:0], lfsr[0]};
            lfsr  = lfsr_step(lfsr);
        end
    endtask

    // Lowest low anode bit or -1 when all off
    function automatic int anode_index(input anode_t an);
        int idx;
        idx = -1;
        for (int i = BCD_DIGITS - 1; i >= 0; i--) begin
            if (an[i] == 1'b0)
                idx = i;
        end
        return idx;
    endfunction

    // Only the shown digit has its anode pulled low
    function automatic anode_t anode_for(input int digit);
        anode_t an;
        an        = '1;
        an[digit] = 1'b0;
        return an;
    endfunction

    function automatic seg_t expected_seg(input bcd_t shown, input int digit);
        int top;
        top = 0;
        for (int i = 0; i < BCD_DIGITS; i++) begin
            if (shown[4*i +: 4] != 4'd0)
                top = i;
        end
        if (digit > top)
            return 7'b1111111;                               // Leading zero stays dark
        return seg_table[shown[4*digit +: 4]];
    endfunction

    // Starts and ends on a falling edge
    task automatic convert(input bin_t value, input bcd_t expected,
                           input logic disturb, input logic hold_enable);
        int cycles;
        bin    = value;
        enable = 1'b1;
        if (ready !== 1'b1)
            stop_on_error("converter was not ready for a new value");
        @(negedge clk);
        if (ready !== 1'b0)
            stop_on_error("conversion was not accepted");
        if (!hold_enable)
            enable = 1'b0;
        cycles = 0;
        while (ready !== 1'b1) begin
            cycles++;
            if (disturb) begin
                bin    = ~bin;                               // Must be ignored while busy
                enable = ~enable;
            end
            @(negedge clk);
        end
        if (!hold_enable)
            enable = 1'b0;                                   // No accept on the next edge
        check_latency(BIN_WIDTH, cycles);
        check_bcd(expected, bcd);
    endtask

    // Align to a digit change, then follow one full scan round
    task automatic check_display(input bcd_t shown);
        int first_digit;
        int digit;
        int waited;
        @(negedge clk);
        first_digit = anode_index(disp.an);
        waited      = 0;
        while (anode_index(disp.an) == first_digit) begin
            if (waited == SCAN_DIV)
                stop_on_error("display anode did not advance");
            waited++;
            @(negedge clk);
        end
        digit = (first_digit + BCD_DIGITS - 1) % BCD_DIGITS;   // Scan counts down
        for (int k = 0; k < 4*SCAN_DIV; k++) begin
            check_anode(anode_for(digit), disp.an);
            check_seg(expected_seg(shown, digit), disp.seg);
            if (k % SCAN_DIV == SCAN_DIV - 1)
                digit = (digit + BCD_DIGITS - 1) % BCD_DIGITS;
            @(negedge clk);
        end
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        stop_on_error("timeout, the tests did not finish in the expected time");
    end

    initial begin
        bin_t value;
        enable = 1'b0;
        bin    = '0;
        lfsr   = LFSR_SEED;
        @(posedge rst_n);
        @(negedge clk);

        // Reset state shows zero on digit 0 only
        if (ready !== 1'b1)
            stop_on_error("ready is not high after reset");
        check_bcd(16'h0000, bcd);
        check_display(16'h0000);

        for (int r = 0; r < NUM_ROWS; r++) begin
            convert(rows[r].value, rows[r].expected, 1'b0, 1'b0);
            check_display(rows[r].expected);
        end

        convert(13'd4321, 16'h4321, 1'b1, 1'b0);            // Inputs wiggle while busy

        convert(13'd2024, 16'h2024, 1'b0, 1'b1);            // Enable held high
        convert(13'd7305, 16'h7305, 1'b0, 1'b0);
        check_display(16'h7305);

        for (int r = 0; r < NUM_RANDOM; r++) begin
            next_random(value);
            convert(value, bcd_model(value), 1'b0, 1'b0);
        end

        if (u_dut.u_assert.fail_count != 0) begin
            stop_on_error("one or more assertions failed");
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    localparam int HALF_PERIOD  = 10;   // 20 ns period
    localparam int RESET_CYCLES = 16;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Reset low for 16 rising edges, released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule
